/* hw/exu_defines.svh */
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// data path and pc width
`define XLEN 64

// integer register file size
`define NUM_REGS 32

// register index width, log2 of NUM_REGS
`define REG_ADDR_W 5

// bytes per memory word, one wmask bit each
`define BYTE_LANES 8

// sequential pc step
`define INST_BYTES 4

`endif

/* hw/exu_pkg.sv */
`include "exu_defines.svh"

package exu_pkg;

    // decoded instruction, one member per kept opcode
    typedef enum logic [7:0] {
        op_nop,
        op_add, op_addi, op_sub,
        op_sll, op_slli, op_slt, op_slti, op_sltu, op_sltiu,
        op_xor, op_xori, op_srl, op_srli, op_sra, op_srai,
        op_or, op_ori, op_and, op_andi,
        // 32-bit word forms
        op_addw, op_addiw, op_subw,
        op_sllw, op_slliw, op_srlw, op_srliw, op_sraw, op_sraiw,
        op_lui, op_auipc, op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld,
        op_sb, op_sh, op_sw, op_sd
    } exec_op_t;

    // alu functions
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_or,
        alu_and
    } alu_mode_t;

    // one decoded instruction with its pc and pre-selected immediate
    typedef struct packed {
        exec_op_t                op;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`REG_ADDR_W-1:0]  rs1;
        logic [`REG_ADDR_W-1:0]  rs2;
        logic [`XLEN-1:0]        imm;
        logic [`XLEN-1:0]        pc;
    } exec_req_t;

    // alu operands plus function
    typedef struct packed {
        alu_mode_t         mode;
        logic              word;
        logic [`XLEN-1:0]  a;
        logic [`XLEN-1:0]  b;
    } alu_in_t;

    // data memory port, async read, store at the edge
    typedef struct packed {
        logic                    read;
        logic                    write;
        logic [`XLEN-1:0]        addr;
        logic [`XLEN-1:0]        wdata;
        logic [`BYTE_LANES-1:0]  wmask;
    } mem_req_t;

endpackage

/* hw/exu_regfile.sv */
`timescale 1ns/100ps
`include "exu_defines.svh"

module exu_regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`REG_ADDR_W-1:0]  rs1,
    input  logic [`REG_ADDR_W-1:0]  rs2,
    output logic [`XLEN-1:0]        src1,
    output logic [`XLEN-1:0]        src2,
    input  logic                    wen,
    input  logic [`REG_ADDR_W-1:0]  waddr,
    input  logic [`XLEN-1:0]        wdata
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

    // clear all on reset, x0 writes dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // async reads, index zero reads zero
    assign src1 = (rs1 == '0) ? '0 : regs[rs1];
    assign src2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hw/exu_operand_sel.sv */
`timescale 1ns/100ps
`include "exu_defines.svh"

module exu_operand_sel import exu_pkg::*; (
    input  exec_req_t               req,
    output logic [`REG_ADDR_W-1:0]  rs1,
    output logic [`REG_ADDR_W-1:0]  rs2,
    input  logic [`XLEN-1:0]        src1,
    input  logic [`XLEN-1:0]        src2,
    output alu_in_t                 alu_in
);

    logic [`XLEN-1:0] shamt_imm;

    // register indices go straight to the file
    assign rs1 = req.rs1;
    assign rs2 = req.rs2;

    // immediate shifts use the 6-bit shamt field only
    assign shamt_imm = {{(`XLEN-6){1'b0}}, req.imm[5:0]};

    always_comb begin
        // default: reg-reg add, no word mode
        alu_in.mode = alu_add;
        alu_in.word = 1'b0;
        alu_in.a    = src1;
        alu_in.b    = src2;
        case (req.op)
            op_add:   alu_in.mode = alu_add;
            op_sub:   alu_in.mode = alu_sub;
            op_sll:   alu_in.mode = alu_sll;
            op_slt:   alu_in.mode = alu_slt;
            op_sltu:  alu_in.mode = alu_sltu;
            op_xor:   alu_in.mode = alu_xor;
            op_srl:   alu_in.mode = alu_srl;
            op_sra:   alu_in.mode = alu_sra;
            op_or:    alu_in.mode = alu_or;
            op_and:   alu_in.mode = alu_and;
            // immediate forms
            op_addi:  begin alu_in.mode = alu_add;  alu_in.b = req.imm; end
            op_slti:  begin alu_in.mode = alu_slt;  alu_in.b = req.imm; end
            op_sltiu: begin alu_in.mode = alu_sltu; alu_in.b = req.imm; end
            op_xori:  begin alu_in.mode = alu_xor;  alu_in.b = req.imm; end
            op_ori:   begin alu_in.mode = alu_or;   alu_in.b = req.imm; end
            op_andi:  begin alu_in.mode = alu_and;  alu_in.b = req.imm; end
            op_slli:  begin alu_in.mode = alu_sll;  alu_in.b = shamt_imm; end
            op_srli:  begin alu_in.mode = alu_srl;  alu_in.b = shamt_imm; end
            op_srai:  begin alu_in.mode = alu_sra;  alu_in.b = shamt_imm; end
            // word forms, alu trims to 5-bit shift and sign-extends
            op_addw:  begin alu_in.mode = alu_add; alu_in.word = 1'b1; end
            op_subw:  begin alu_in.mode = alu_sub; alu_in.word = 1'b1; end
            op_sllw:  begin alu_in.mode = alu_sll; alu_in.word = 1'b1; end
            op_srlw:  begin alu_in.mode = alu_srl; alu_in.word = 1'b1; end
            op_sraw:  begin alu_in.mode = alu_sra; alu_in.word = 1'b1; end
            op_addiw: begin
                alu_in.mode = alu_add;
                alu_in.word = 1'b1;
                alu_in.b    = req.imm;
            end
            op_slliw, op_srliw, op_sraiw: begin
                alu_in.mode = (req.op == op_slliw) ? alu_sll :
                              (req.op == op_srliw) ? alu_srl : alu_sra;
                alu_in.word = 1'b1;
                alu_in.b    = shamt_imm;
            end
            // lui passes imm through a zero a
            op_lui: begin
                alu_in.a = '0;
                alu_in.b = req.imm;
            end
            // pc relative targets
            op_auipc, op_jal: begin
                alu_in.a = req.pc;
                alu_in.b = req.imm;
            end
            // base plus offset addressing
            op_jalr, op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld,
            op_sb, op_sh, op_sw, op_sd: begin
                alu_in.b = req.imm;
            end
            // branches subtract, decision itself is in next pc
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                alu_in.mode = alu_sub;
            end
            default: ;
        endcase
    end

endmodule

/* hw/exu_alu.sv */
`timescale 1ns/100ps
`include "exu_defines.svh"

module exu_alu import exu_pkg::*; (
    input  alu_in_t           alu_in,
    output logic [`XLEN-1:0]  result
);

    logic [5:0]        shamt;
    logic [`XLEN-1:0]  srl_src;
    logic [`XLEN-1:0]  sra_src;
    logic [`XLEN-1:0]  raw;

    // word mode limits shift to 5 bits
    assign shamt = alu_in.word ? {1'b0, alu_in.b[4:0]} : alu_in.b[5:0];

    // right shifts in word mode see only the low word
    assign srl_src = alu_in.word ? {32'b0, alu_in.a[31:0]} : alu_in.a;
    assign sra_src = alu_in.word ? {{32{alu_in.a[31]}}, alu_in.a[31:0]} : alu_in.a;

    always_comb begin
        case (alu_in.mode)
            alu_add:  raw = alu_in.a + alu_in.b;
            alu_sub:  raw = alu_in.a - alu_in.b;
            alu_sll:  raw = alu_in.a << shamt;
            alu_srl:  raw = srl_src >> shamt;
            alu_sra:  raw = $signed(sra_src) >>> shamt;
            // compares give 0 or 1
            alu_slt:  raw = {{(`XLEN-1){1'b0}}, $signed(alu_in.a) < $signed(alu_in.b)};
            alu_sltu: raw = {{(`XLEN-1){1'b0}}, alu_in.a < alu_in.b};
            alu_xor:  raw = alu_in.a ^ alu_in.b;
            alu_or:   raw = alu_in.a | alu_in.b;
            alu_and:  raw = alu_in.a & alu_in.b;
            default:  raw = '0;
        endcase
    end

    // word results sign-extend from bit 31
    assign result = alu_in.word ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

/* hw/exu_next_pc.sv */
`timescale 1ns/100ps
`include "exu_defines.svh"

module exu_next_pc import exu_pkg::*; (
    input  exec_req_t         req,
    input  logic [`XLEN-1:0]  src1,
    input  logic [`XLEN-1:0]  src2,
    input  logic [`XLEN-1:0]  alu_result,
    output logic [`XLEN-1:0]  dnpc
);

    logic [`XLEN-1:0]  snpc;
    logic [`XLEN-1:0]  btarget;
    logic              taken;

    // fall-through and branch target
    assign snpc    = req.pc + `INST_BYTES;
    assign btarget = req.pc + req.imm;

    // compare operands directly, not via the alu
    always_comb begin
        case (req.op)
            op_beq:  taken = (src1 == src2);
            op_bne:  taken = (src1 != src2);
            op_blt:  taken = ($signed(src1) < $signed(src2));
            op_bge:  taken = ($signed(src1) >= $signed(src2));
            op_bltu: taken = (src1 < src2);
            op_bgeu: taken = (src1 >= src2);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (req.op)
            op_jal:  dnpc = alu_result;
            // jalr clears the low target bit
            op_jalr: dnpc = {alu_result[`XLEN-1:1], 1'b0};
            default: dnpc = taken ? btarget : snpc;
        endcase
    end

endmodule

/* hw/exu_lsu.sv */
`timescale 1ns/100ps
`include "exu_defines.svh"

module exu_lsu import exu_pkg::*; (
    input  logic              rst,
    input  exec_req_t         req,
    input  logic [`XLEN-1:0]  alu_result,
    input  logic [`XLEN-1:0]  src2,
    input  logic [`XLEN-1:0]  mem_rdata,
    output mem_req_t          mem,
    output logic [`XLEN-1:0]  load_data
);

    logic                    is_load;
    logic                    is_store;
    logic [2:0]              lane;
    logic [5:0]              lane_bits;
    logic [`BYTE_LANES-1:0]  size_mask;
    logic [`XLEN-1:0]        store_src;
    logic [`XLEN-1:0]        rdata_shift;

    always_comb begin
        case (req.op)
            op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld: is_load = 1'b1;
            default: is_load = 1'b0;
        endcase
    end

    // store width as a byte mask at lane 0, data trimmed to match
    always_comb begin
        is_store  = 1'b1;
        size_mask = '0;
        store_src = '0;
        case (req.op)
            op_sb: begin
                size_mask = 8'h01;
                store_src = {56'b0, src2[7:0]};
            end
            op_sh: begin
                size_mask = 8'h03;
                store_src = {48'b0, src2[15:0]};
            end
            op_sw: begin
                size_mask = 8'h0f;
                store_src = {32'b0, src2[31:0]};
            end
            op_sd: begin
                size_mask = 8'hff;
                store_src = src2;
            end
            default: is_store = 1'b0;
        endcase
    end

    // byte lane from the low address bits
    assign lane      = alu_result[2:0];
    assign lane_bits = {lane, 3'b000};

    // same address for load and store
    assign mem.addr  = alu_result;
    assign mem.read  = is_load && !rst;
    assign mem.write = is_store && !rst;

    // accesses crossing the 8-byte word are not supported, upper bytes drop
    // zero data and mask unless a store is going out
    assign mem.wdata = mem.write ? (store_src << lane_bits) : '0;
    assign mem.wmask = mem.write ? (size_mask << lane) : '0;

    // addressed lane moved down to bit 0
    assign rdata_shift = mem_rdata >> lane_bits;

    // sign or zero extension per load type
    always_comb begin
        case (req.op)
            op_lb:   load_data = {{56{rdata_shift[7]}}, rdata_shift[7:0]};
            op_lh:   load_data = {{48{rdata_shift[15]}}, rdata_shift[15:0]};
            op_lw:   load_data = {{32{rdata_shift[31]}}, rdata_shift[31:0]};
            op_lbu:  load_data = {56'b0, rdata_shift[7:0]};
            op_lhu:  load_data = {48'b0, rdata_shift[15:0]};
            op_lwu:  load_data = {32'b0, rdata_shift[31:0]};
            op_ld:   load_data = mem_rdata;
            default: load_data = '0;
        endcase
    end

endmodule

/* hw/exu_writeback.sv */
`timescale 1ns/100ps
`include "exu_defines.svh"

module exu_writeback import exu_pkg::*; (
    input  logic                    rst,
    input  exec_req_t               req,
    input  logic [`XLEN-1:0]        alu_result,
    input  logic [`XLEN-1:0]        load_data,
    output logic                    wen,
    output logic [`REG_ADDR_W-1:0]  waddr,
    output logic [`XLEN-1:0]        wdata
);

    logic wr_op;

    // no register result for branches, stores and nop
    always_comb begin
        case (req.op)
            op_nop,
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
            op_sb, op_sh, op_sw, op_sd: wr_op = 1'b0;
            default: wr_op = 1'b1;
        endcase
    end

    // held off during reset, x0 filtered in the register file
    assign wen   = wr_op && !rst;
    assign waddr = req.rd;

    always_comb begin
        case (req.op)
            op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld:
                wdata = load_data;
            // link address
            op_jal, op_jalr:
                wdata = req.pc + `INST_BYTES;
            default:
                wdata = alu_result;
        endcase
    end

endmodule

/* hw/exu_top.sv */
`timescale 1ns/100ps
`include "exu_defines.svh"

module exu_top import exu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  exec_req_t         req,
    input  logic [`XLEN-1:0]  mem_rdata,
    output mem_req_t          mem,
    output logic [`XLEN-1:0]  dnpc
);

    logic [`REG_ADDR_W-1:0]  rs1;
    logic [`REG_ADDR_W-1:0]  rs2;
    logic [`XLEN-1:0]        src1;
    logic [`XLEN-1:0]        src2;
    alu_in_t                 alu_in;
    logic [`XLEN-1:0]        alu_result;
    logic [`XLEN-1:0]        load_data;
    logic                    wen;
    logic [`REG_ADDR_W-1:0]  waddr;
    logic [`XLEN-1:0]        wdata;

    // register file, written at the end of the cycle
    exu_regfile u_exu_regfile (
        .clk   (clk),
        .rst   (rst),
        .rs1   (rs1),
        .rs2   (rs2),
        .src1  (src1),
        .src2  (src2),
        .wen   (wen),
        .waddr (waddr),
        .wdata (wdata)
    );

    exu_operand_sel u_exu_operand_sel (
        .req    (req),
        .rs1    (rs1),
        .rs2    (rs2),
        .src1   (src1),
        .src2   (src2),
        .alu_in (alu_in)
    );

    exu_alu u_exu_alu (
        .alu_in (alu_in),
        .result (alu_result)
    );

    exu_next_pc u_exu_next_pc (
        .req        (req),
        .src1       (src1),
        .src2       (src2),
        .alu_result (alu_result),
        .dnpc       (dnpc)
    );

    // memory port and load alignment
    exu_lsu u_exu_lsu (
        .rst        (rst),
        .req        (req),
        .alu_result (alu_result),
        .src2       (src2),
        .mem_rdata  (mem_rdata),
        .mem        (mem),
        .load_data  (load_data)
    );

    exu_writeback u_exu_writeback (
        .rst        (rst),
        .req        (req),
        .alu_result (alu_result),
        .load_data  (load_data),
        .wen        (wen),
        .waddr      (waddr),
        .wdata      (wdata)
    );

endmodule

/* sim/exu_props.sv */
`timescale 1ns/100ps
`include "exu_defines.svh"

module exu_props import exu_pkg::*; (
    input logic      clk,
    input logic      rst,
    input mem_req_t  mem
);

    logic [`XLEN-1:0] lane_mask;

    // byte enables widened to bit enables
    always_comb begin
        for (int i = 0; i < `BYTE_LANES; i++) begin
            lane_mask[8*i +: 8] = {8{mem.wmask[i]}};
        end
    end

    // port carries a load or a store, never both
    a_one_access: assert property (@(posedge clk) !(mem.read && mem.write))
        else $error("memory read and write high together");

    a_mask_follows_write: assert property (@(posedge clk) (mem.wmask != '0) == mem.write)
        else $error("wmask does not match write");

    a_data_in_mask: assert property (@(posedge clk) (mem.wdata & ~lane_mask) == '0)
        else $error("wdata bits set outside wmask");

    a_no_write_in_reset: assert property (@(posedge clk) rst |-> !mem.write)
        else $error("memory write while reset is high");

endmodule

bind exu_top exu_props u_exu_props (
    .clk (clk),
    .rst (rst),
    .mem (mem)
);

/* sim/exu_tb.sv */
`timescale 1ns/100ps
`include "exu_defines.svh"

module exu_tb import exu_pkg::*; ();

    // model view of one instruction
    typedef struct packed {
        logic [`XLEN-1:0]        dnpc;
        mem_req_t                mem;
        logic                    wen;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [`XLEN-1:0]        wdata;
    } model_out_t;

    logic              clk;
    logic              rst;
    exec_req_t         req;
    logic [`XLEN-1:0]  mem_rdata;
    mem_req_t          mem;
    logic [`XLEN-1:0]  dnpc;

    // 2 KiB data memory shared by dut and model
    logic [`XLEN-1:0]  mem_model [256];
    logic [`XLEN-1:0]  model_regs [`NUM_REGS];
    exec_req_t         prog [$];
    string             names [$];
    model_out_t        exp_out;
    logic [31:0]       seed = 32'heba1;
    logic              active;
    int                cur_idx;
    int                err_xlen;
    int                err_mem;
    int                err_other;
    int                checked;
    int                cycles;
    int                max_cycles;

    exu_top u_exu_top (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .mem_rdata (mem_rdata),
        .mem       (mem),
        .dnpc      (dnpc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // async read port
    assign mem_rdata = mem_model[mem.addr[10:3]];

    // stores land at the edge byte by byte
    always @(posedge clk) begin
        if (mem.write) begin
            for (int i = 0; i < `BYTE_LANES; i++) begin
                if (mem.wmask[i]) begin
                    mem_model[mem.addr[10:3]][8*i +: 8] <= mem.wdata[8*i +: 8];
                end
            end
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    function automatic logic [`XLEN-1:0] rand64();
        logic [`XLEN-1:0] v;
        v[63:32] = next_rand();
        v[31:0]  = next_rand();
        return v;
    endfunction

    // aligned doubleword in the upper kilobyte
    function automatic logic [`XLEN-1:0] rand_slot();
        return 64'h400 + {next_rand() & 32'h7f, 3'b000};
    endfunction

    function automatic logic [`XLEN-1:0] sext_word(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic model_out_t expected_result(input exec_req_t r,
                                                   input logic [`XLEN-1:0] regs [`NUM_REGS],
                                                   input logic [`XLEN-1:0] dmem [256]);
        model_out_t        o;
        logic [`XLEN-1:0]  a;
        logic [`XLEN-1:0]  b;
        logic [`XLEN-1:0]  ea;
        logic [`XLEN-1:0]  word;
        logic              taken;
        int                lane;
        int                size;
        a    = regs[r.rs1];
        b    = regs[r.rs2];
        ea   = a + r.imm;
        lane = ea[2:0];
        // addressed bytes brought down to bit 0
        word = dmem[ea[10:3]] >> (8 * lane);
        o        = '0;
        o.dnpc   = r.pc + `INST_BYTES;
        o.rd     = r.rd;
        o.wen    = 1'b1;
        case (r.op)
            op_beq:  taken = (a == b);
            op_bne:  taken = (a != b);
            op_blt:  taken = ($signed(a) < $signed(b));
            op_bge:  taken = ($signed(a) >= $signed(b));
            op_bltu: taken = (a < b);
            op_bgeu: taken = (a >= b);
            default: taken = 1'b0;
        endcase
        case (r.op)
            op_add:   o.wdata = a + b;
            op_addi:  o.wdata = a + r.imm;
            op_sub:   o.wdata = a - b;
            op_sll:   o.wdata = a << b[5:0];
            op_slli:  o.wdata = a << r.imm[5:0];
            op_slt:   o.wdata = ($signed(a) < $signed(b)) ? 1 : 0;
            op_slti:  o.wdata = ($signed(a) < $signed(r.imm)) ? 1 : 0;
            op_sltu:  o.wdata = (a < b) ? 1 : 0;
            op_sltiu: o.wdata = (a < r.imm) ? 1 : 0;
            op_xor:   o.wdata = a ^ b;
            op_xori:  o.wdata = a ^ r.imm;
            op_srl:   o.wdata = a >> b[5:0];
            op_srli:  o.wdata = a >> r.imm[5:0];
            op_sra:   o.wdata = $signed(a) >>> b[5:0];
            op_srai:  o.wdata = $signed(a) >>> r.imm[5:0];
            op_or:    o.wdata = a | b;
            op_ori:   o.wdata = a | r.imm;
            op_and:   o.wdata = a & b;
            op_andi:  o.wdata = a & r.imm;
            // word forms see only the low 32 bits
            op_addw:  o.wdata = sext_word(a[31:0] + b[31:0]);
            op_addiw: o.wdata = sext_word(a[31:0] + r.imm[31:0]);
            op_subw:  o.wdata = sext_word(a[31:0] - b[31:0]);
            op_sllw:  o.wdata = sext_word(a[31:0] << b[4:0]);
            op_slliw: o.wdata = sext_word(a[31:0] << r.imm[4:0]);
            op_srlw:  o.wdata = sext_word(a[31:0] >> b[4:0]);
            op_srliw: o.wdata = sext_word(a[31:0] >> r.imm[4:0]);
            op_sraw:  o.wdata = sext_word($signed(a[31:0]) >>> b[4:0]);
            op_sraiw: o.wdata = sext_word($signed(a[31:0]) >>> r.imm[4:0]);
            op_lui:   o.wdata = r.imm;
            op_auipc: o.wdata = r.pc + r.imm;
            op_jal: begin
                o.dnpc  = r.pc + r.imm;
                o.wdata = r.pc + `INST_BYTES;
            end
            op_jalr: begin
                o.dnpc  = ea & ~64'h1;
                o.wdata = r.pc + `INST_BYTES;
            end
            op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu: begin
                o.wen = 1'b0;
                if (taken) begin
                    o.dnpc = r.pc + r.imm;
                end
            end
            op_lb, op_lh, op_lw, op_lbu, op_lhu, op_lwu, op_ld: begin
                o.mem.read = 1'b1;
                o.mem.addr = ea;
                case (r.op)
                    op_lb:   o.wdata = {{56{word[7]}}, word[7:0]};
                    op_lh:   o.wdata = {{48{word[15]}}, word[15:0]};
                    op_lw:   o.wdata = sext_word(word[31:0]);
                    op_lbu:  o.wdata = {56'b0, word[7:0]};
                    op_lhu:  o.wdata = {48'b0, word[15:0]};
                    op_lwu:  o.wdata = {32'b0, word[31:0]};
                    default: o.wdata = word;
                endcase
            end
            op_sb, op_sh, op_sw, op_sd: begin
                o.wen       = 1'b0;
                o.mem.write = 1'b1;
                o.mem.addr  = ea;
                size = (r.op == op_sb) ? 1 : (r.op == op_sh) ? 2 : (r.op == op_sw) ? 4 : 8;
                // bytes of rs2 fill lanes lane .. lane+size-1
                for (int i = 0; i < `BYTE_LANES; i++) begin
                    if (i >= lane && i < lane + size) begin
                        o.mem.wmask[i]         = 1'b1;
                        o.mem.wdata[8*i +: 8] = b[8*(i-lane) +: 8];
                    end
                end
            end
            default: o.wen = 1'b0;
        endcase
        return o;
    endfunction

    function automatic string mem_text(input mem_req_t m);
        return $sformatf("rd=%b wr=%b addr=%h wdata=%h wmask=%h",
                         m.read, m.write, m.addr, m.wdata, m.wmask);
    endfunction

    task automatic check_xlen(input string name, input logic [`XLEN-1:0] exp,
                              input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            err_xlen++;
            $display("Error %s expected %h actual %h", name, exp, act);
        end
    endtask

    // addr only matters when an access is expected
    task automatic check_mem(input string name, input mem_req_t exp, input mem_req_t act);
        logic addr_bad;
        addr_bad = (exp.read || exp.write) && (act.addr !== exp.addr);
        if (addr_bad || act.read !== exp.read || act.write !== exp.write ||
            act.wdata !== exp.wdata || act.wmask !== exp.wmask) begin
            err_mem++;
            $display("Error %s expected %s actual %s", name, mem_text(exp), mem_text(act));
        end
    endtask

    task automatic push_instr(input string name, input exec_op_t op, input int rd,
                              input int rs1, input int rs2, input logic [`XLEN-1:0] imm);
        exec_req_t r;
        r.op  = op;
        r.rd  = rd[`REG_ADDR_W-1:0];
        r.rs1 = rs1[`REG_ADDR_W-1:0];
        r.rs2 = rs2[`REG_ADDR_W-1:0];
        r.imm = imm;
        // straight-line pcs since dnpc is only reported
        r.pc  = 64'h8000_0000 + `INST_BYTES * prog.size();
        prog.push_back(r);
        names.push_back(name);
    endtask

    // lui passes any 64-bit imm through
    task automatic set_reg(input string name, input int rd, input logic [`XLEN-1:0] v);
        push_instr(name, op_lui, rd, 0, 0, v);
    endtask

    task automatic store_reg(input string name, input int rs, input logic [`XLEN-1:0] addr);
        push_instr(name, op_sd, 0, 0, rs, addr);
    endtask

    task automatic store_lane(input string name, input exec_op_t op, input logic [`XLEN-1:0] addr);
        set_reg({name, " data"}, 10, rand64());
        push_instr(name, op, 0, 0, 10, addr);
    endtask

    task automatic load_back(input string name, input exec_op_t op, input logic [`XLEN-1:0] addr);
        push_instr(name, op, 11, 0, 0, addr);
        store_reg({name, " value"}, 11, rand_slot());
    endtask

    task automatic build_program();
        exec_op_t          alu_ops [$];
        exec_op_t          word_ops [$];
        exec_op_t          br_ops [$];
        logic [`XLEN-1:0]  va;
        logic [`XLEN-1:0]  vb;
        alu_ops  = '{op_add, op_addi, op_sub, op_sll, op_slli, op_slt, op_slti, op_sltu,
                     op_sltiu, op_xor, op_xori, op_srl, op_srli, op_sra, op_srai, op_or,
                     op_ori, op_and, op_andi, op_lui, op_auipc};
        word_ops = '{op_addw, op_addiw, op_subw, op_sllw, op_slliw, op_srlw, op_srliw,
                     op_sraw, op_sraiw};
        br_ops   = '{op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
        // registers cleared by reset and x0 stays zero after writes
        store_reg("x1 after reset", 1, rand_slot());
        store_reg("x0 after reset", 0, rand_slot());
        set_reg("x5 load", 5, rand64());
        set_reg("lui to x0", 0, rand64());
        push_instr("addi to x0", op_addi, 0, 5, 0, rand64());
        store_reg("x0 after writes", 0, rand_slot());
        // alu ops with alternating operand signs
        for (int i = 0; i < 2 * alu_ops.size(); i++) begin
            va     = rand64();
            vb     = rand64();
            va[63] = (i % 2 == 0);
            vb[63] = (i % 2 != 0);
            set_reg("alu a", 5, va);
            set_reg("alu b", 6, vb);
            push_instr($sformatf("alu op %0d", i), alu_ops[i % alu_ops.size()], 7, 5, 6, rand64());
            store_reg("alu result", 7, rand_slot());
        end
        // word ops with the low word near the top so bit 31 is mostly set
        // shift amount bit 5 set at times, word mode must drop it
        for (int i = 0; i < 2 * word_ops.size(); i++) begin
            va        = rand64();
            va[31:28] = 4'hf;
            vb        = rand64() & 64'h23;
            set_reg("word a", 5, va);
            set_reg("word b", 6, vb);
            push_instr($sformatf("word op %0d", i), word_ops[i % word_ops.size()], 7, 5, 6, vb);
            store_reg("word result", 7, rand_slot());
        end
        // neg vs pos, pos vs neg, equal
        for (int p = 0; p < 3; p++) begin
            va     = rand64();
            va[63] = (p == 0);
            vb     = rand64();
            vb[63] = (p == 1);
            if (p == 2) begin
                vb = va;
            end
            set_reg("branch a", 5, va);
            set_reg("branch b", 6, vb);
            foreach (br_ops[k]) begin
                push_instr($sformatf("branch %0d/%0d", p, k), br_ops[k], 0, 5, 6,
                           rand64() & ~64'h1);
            end
        end
        // even base plus odd offset gives an odd jalr target
        set_reg("jalr base", 5, rand64() & ~64'h1);
        push_instr("jal", op_jal, 8, 0, 0, rand64() & ~64'h1);
        push_instr("jalr odd target", op_jalr, 9, 5, 0, rand64() | 64'h1);
        store_reg("jal link", 8, rand_slot());
        store_reg("jalr link", 9, rand_slot());
        // store every aligned lane then read back each way
        for (int i = 0; i < 8; i++) begin
            store_lane($sformatf("sb lane %0d", i), op_sb, 64'h100 + i);
        end
        for (int i = 0; i < 8; i += 2) begin
            store_lane($sformatf("sh lane %0d", i), op_sh, 64'h108 + i);
        end
        for (int i = 0; i < 8; i += 4) begin
            store_lane($sformatf("sw lane %0d", i), op_sw, 64'h110 + i);
        end
        store_lane("sd", op_sd, 64'h118);
        for (int i = 0; i < 8; i++) begin
            load_back($sformatf("lb lane %0d", i), op_lb, 64'h100 + i);
            load_back($sformatf("lbu lane %0d", i), op_lbu, 64'h100 + i);
        end
        for (int i = 0; i < 8; i += 2) begin
            load_back($sformatf("lh lane %0d", i), op_lh, 64'h108 + i);
            load_back($sformatf("lhu lane %0d", i), op_lhu, 64'h108 + i);
        end
        for (int i = 0; i < 8; i += 4) begin
            load_back($sformatf("lw lane %0d", i), op_lw, 64'h110 + i);
            load_back($sformatf("lwu lane %0d", i), op_lwu, 64'h110 + i);
        end
        load_back("ld", op_ld, 64'h118);
    endtask

    // compare 1 ns before the edge that retires the instruction
    always begin
        @(posedge clk);
        #19;
        if (rst) begin
            if (mem.read || mem.write) begin
                err_other++;
                $display("memory access seen while reset is high");
            end
        end else if (active) begin
            exp_out = expected_result(prog[cur_idx], model_regs, mem_model);
            check_xlen($sformatf("%s #%0d dnpc", names[cur_idx], cur_idx), exp_out.dnpc, dnpc);
            check_mem($sformatf("%s #%0d mem", names[cur_idx], cur_idx), exp_out.mem, mem);
            if (exp_out.wen && exp_out.rd != '0) begin
                model_regs[exp_out.rd] = exp_out.wdata;
            end
            checked++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout after %0d cycles, %0d of %0d instructions checked",
                     cycles, checked, prog.size());
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        err_xlen  = 0;
        err_mem   = 0;
        err_other = 0;
        checked   = 0;
        cycles    = 0;
        active    = 1'b0;
        cur_idx   = 0;
        // fill depends on the full word index
        for (int i = 0; i < 256; i++) begin
            mem_model[i] = {i * 32'h9e37_79b9, ~(i * 32'h85eb_ca6b)};
        end
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        build_program();
        max_cycles = 2 * prog.size() + 20;
        rst = 1'b1;
        // a store and then a load held on req must not reach memory during reset
        req     = '0;
        req.op  = op_sd;
        req.rs2 = 5'd3;
        req.imm = 64'h200;
        repeat (2) @(posedge clk);
        #2;
        req.op  = op_ld;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            if (i > 0) begin
                @(posedge clk);
                #2;
            end
            cur_idx = i;
            req     = prog[i];
            active  = 1'b1;
        end
        @(posedge clk);
        #2;
        active = 1'b0;
        req    = '0;
        repeat (2) @(posedge clk);
        $display("checked %0d instructions, errors dnpc %0d mem %0d other %0d",
                 checked, err_xlen, err_mem, err_other);
        if (err_xlen == 0 && err_mem == 0 && err_other == 0 && checked == prog.size()) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+hw
hw/exu_pkg.sv
hw/exu_regfile.sv
hw/exu_operand_sel.sv
hw/exu_alu.sv
hw/exu_next_pc.sv
hw/exu_lsu.sv
hw/exu_writeback.sv
hw/exu_top.sv
sim/exu_props.sv
sim/exu_tb.sv

/* Bender.yml */
package:
  name: exu

sources:
  - include_dirs:
      - hw
    files:
      - hw/exu_pkg.sv
      - hw/exu_regfile.sv
      - hw/exu_operand_sel.sv
      - hw/exu_alu.sv
      - hw/exu_next_pc.sv
      - hw/exu_lsu.sv
      - hw/exu_writeback.sv
      - hw/exu_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/exu_props.sv
      - sim/exu_tb.sv
